// ==== design/decoder_pkg.sv ====
package decoder_pkg;

    // Lattice geometry
    localparam int GRID_ROWS = 4;
    localparam int GRID_COLS = 5;
    localparam int UNIT_COUNT = GRID_ROWS * GRID_COLS;
    localparam int ADDR_W = $clog2(UNIT_COUNT);

    // Edge counts in result order
    localparam int NS_EDGE_COUNT = (GRID_ROWS - 1) * GRID_COLS;
    localparam int EW_EDGE_COUNT = GRID_ROWS * (GRID_COLS - 1);
    localparam int BND_EDGE_COUNT = 2 * GRID_ROWS;  // West column then east column
    localparam int EDGE_COUNT = NS_EDGE_COUNT + EW_EDGE_COUNT + BND_EDGE_COUNT;

    typedef logic [ADDR_W-1:0] unit_addr_t;  // row * GRID_COLS + col

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        GROW,
        MERGE,
        CHECK,
        DONE
    } phase_e;

    typedef enum logic [1:0] {
        NORTH,
        SOUTH,
        WEST,
        EAST
    } dir_e;

    typedef struct packed {
        unit_addr_t root;
        logic       boundary;  // Cluster member touches a grown boundary edge
    } unit_status_t;

    typedef struct packed {
        unit_addr_t [UNIT_COUNT-1:0] roots;
        logic [EDGE_COUNT-1:0]       grown;  // NS, EW, west boundary, east boundary
    } decode_result_t;

endpackage

// ==== design/edge_link.sv ====
`timescale 1ns/100ps

module edge_link #(
    parameter int MAX_WEIGHT  = 2,
    parameter bit IS_BOUNDARY = 1'b0
) (
    input  logic                clk,
    input  logic                reset,
    input  decoder_pkg::phase_e phase_i,
    input  logic                grow_a_i,
    input  logic                grow_b_i,
    output logic                grown_o
);
    import decoder_pkg::*;

    localparam int CNT_W = $clog2(MAX_WEIGHT + 1);

    logic [CNT_W-1:0] count_q;
    logic [1:0]       step;
    logic [CNT_W:0]   count_sum;  // One spare bit before saturation

    always_comb begin
        step      = {1'b0, grow_a_i} + {1'b0, (IS_BOUNDARY ? 1'b0 : grow_b_i)};
        count_sum = {1'b0, count_q} + (CNT_W + 1)'(step);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (phase_i == LOAD) begin
            count_q <= '0;
        end else if (phase_i == GROW) begin
            if (count_sum >= (CNT_W + 1)'(MAX_WEIGHT)) begin
                count_q <= CNT_W'(MAX_WEIGHT);
            end else begin
                count_q <= count_sum[CNT_W-1:0];
            end
        end
    end

    assign grown_o = (count_q == CNT_W'(MAX_WEIGHT));

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        (phase_i == GROW) |=> (count_q <= MAX_WEIGHT)
    );

endmodule

// ==== design/processing_unit.sv ====
`timescale 1ns/100ps

module processing_unit #(
    parameter decoder_pkg::unit_addr_t ADDRESS = '0
) (
    input  logic                               clk,
    input  logic                               reset,
    input  decoder_pkg::phase_e                phase_i,
    input  logic                               defect_i,
    input  logic                               odd_i,
    input  decoder_pkg::unit_addr_t [3:0]      neighbor_root_i,
    input  logic [3:0]                         neighbor_grown_i,
    output logic                               grow_o,
    output decoder_pkg::unit_status_t          status_o,
    output logic                               busy_o
);
    import decoder_pkg::*;

    localparam int COL = ADDRESS % GRID_COLS;

    logic [3:0] is_bnd;  // Links on this side go to the boundary
    unit_addr_t root_q;
    unit_addr_t min_root;
    logic       busy_q;
    logic       defect_q;

    always_comb begin
        is_bnd        = '0;
        is_bnd[WEST]  = (COL == 0);
        is_bnd[EAST]  = (COL == GRID_COLS - 1);
    end

    // Smallest root over self and fully grown internal links
    always_comb begin
        min_root = root_q;
        for (int d = 0; d < 4; d++) begin
            if (neighbor_grown_i[d] && !is_bnd[d] && (neighbor_root_i[d] < min_root)) begin
                min_root = neighbor_root_i[d];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            root_q <= ADDRESS;
            busy_q <= 1'b0;
        end else begin
            case (phase_i)
                LOAD: begin
                    root_q <= ADDRESS;
                    busy_q <= 1'b0;
                end
                GROW: begin
                    busy_q <= 1'b1;  // New grown links may open merges
                end
                MERGE: begin
                    root_q <= min_root;
                    busy_q <= (min_root != root_q);
                end
                default: begin
                    root_q <= root_q;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase_i == LOAD) begin
            defect_q <= defect_i;
        end
    end

    assign grow_o            = (phase_i == GROW) && odd_i;
    assign busy_o            = busy_q;
    assign status_o.root     = root_q;
    assign status_o.boundary = |(neighbor_grown_i & is_bnd);

    a_root_monotone: assert property (
        @(posedge clk) disable iff (reset)
        (phase_i != LOAD) |=> (root_q <= $past(root_q))
    );

    // An isolated defect forms a cluster of one, so parity must call it odd
    a_lone_defect_odd: assert property (
        @(posedge clk) disable iff (reset)
        ((phase_i == CHECK) && defect_q && (neighbor_grown_i == '0)) |-> odd_i
    );

endmodule

// ==== design/cluster_parity.sv ====
`timescale 1ns/100ps

module cluster_parity (
    input  decoder_pkg::unit_status_t [decoder_pkg::UNIT_COUNT-1:0] status_i,
    input  logic [decoder_pkg::UNIT_COUNT-1:0]                      defect_i,
    output logic [decoder_pkg::UNIT_COUNT-1:0]                      odd_o,
    output logic                                                    any_odd_o
);
    import decoder_pkg::*;

    // Indexed by root address, not by unit
    logic [UNIT_COUNT-1:0] root_parity;
    logic [UNIT_COUNT-1:0] root_touch;

    // Gather every unit into the entry of its root
    always_comb begin
        root_parity = '0;
        root_touch  = '0;
        for (int a = 0; a < UNIT_COUNT; a++) begin
            for (int u = 0; u < UNIT_COUNT; u++) begin
                if (status_i[u].root == unit_addr_t'(a)) begin
                    root_parity[a] = root_parity[a] ^ defect_i[u];
                    root_touch[a]  = root_touch[a] | status_i[u].boundary;
                end
            end
        end
    end

    // Spread the per-root result back to every member
    always_comb begin
        for (int u = 0; u < UNIT_COUNT; u++) begin
            odd_o[u] = root_parity[status_i[u].root] && !root_touch[status_i[u].root];
        end
        any_odd_o = |odd_o;
    end

endmodule

// ==== design/decoding_lattice.sv ====
`timescale 1ns/100ps

module decoding_lattice #(
    parameter int MAX_WEIGHT = 2
) (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  decoder_pkg::phase_e                                     phase_i,
    input  logic [decoder_pkg::UNIT_COUNT-1:0]                      frame_i,
    input  logic [decoder_pkg::UNIT_COUNT-1:0]                      odd_i,
    output decoder_pkg::unit_status_t [decoder_pkg::UNIT_COUNT-1:0] status_o,
    output logic                                                    any_busy_o,
    output decoder_pkg::decode_result_t                             result_o
);
    import decoder_pkg::*;

    logic [UNIT_COUNT-1:0]     unit_grow;
    logic [UNIT_COUNT-1:0]     unit_busy;
    logic [NS_EDGE_COUNT-1:0]  ns_grown;   // Indexed by upper unit
    logic [EW_EDGE_COUNT-1:0]  ew_grown;   // Indexed by west unit
    logic [BND_EDGE_COUNT-1:0] bnd_grown;  // West rows, then east rows

    for (genvar r = 0; r < GRID_ROWS; r++) begin : g_row
        for (genvar c = 0; c < GRID_COLS; c++) begin : g_col
            localparam int U = r * GRID_COLS + c;

            unit_addr_t [3:0] nb_root;
            logic [3:0]       nb_grown;

            // Missing or boundary sides feed back the own address
            if (r > 0) begin : g_n
                assign nb_root[NORTH]  = status_o[U-GRID_COLS].root;
                assign nb_grown[NORTH] = ns_grown[U-GRID_COLS];
            end else begin : g_n_edge
                assign nb_root[NORTH]  = unit_addr_t'(U);
                assign nb_grown[NORTH] = 1'b0;
            end
            if (r < GRID_ROWS - 1) begin : g_s
                assign nb_root[SOUTH]  = status_o[U+GRID_COLS].root;
                assign nb_grown[SOUTH] = ns_grown[U];
            end else begin : g_s_edge
                assign nb_root[SOUTH]  = unit_addr_t'(U);
                assign nb_grown[SOUTH] = 1'b0;
            end
            if (c > 0) begin : g_w
                assign nb_root[WEST]  = status_o[U-1].root;
                assign nb_grown[WEST] = ew_grown[r*(GRID_COLS-1)+c-1];
            end else begin : g_w_bnd
                assign nb_root[WEST]  = unit_addr_t'(U);
                assign nb_grown[WEST] = bnd_grown[r];
            end
            if (c < GRID_COLS - 1) begin : g_e
                assign nb_root[EAST]  = status_o[U+1].root;
                assign nb_grown[EAST] = ew_grown[r*(GRID_COLS-1)+c];
            end else begin : g_e_bnd
                assign nb_root[EAST]  = unit_addr_t'(U);
                assign nb_grown[EAST] = bnd_grown[GRID_ROWS+r];
            end

            processing_unit #(
                .ADDRESS (unit_addr_t'(U))
            ) u_pu (
                .clk              (clk),
                .reset            (reset),
                .phase_i          (phase_i),
                .defect_i         (frame_i[U]),
                .odd_i            (odd_i[U]),
                .neighbor_root_i  (nb_root),
                .neighbor_grown_i (nb_grown),
                .grow_o           (unit_grow[U]),
                .status_o         (status_o[U]),
                .busy_o           (unit_busy[U])
            );
        end
    end

    for (genvar e = 0; e < NS_EDGE_COUNT; e++) begin : g_ns
        edge_link #(.MAX_WEIGHT(MAX_WEIGHT), .IS_BOUNDARY(1'b0)) u_link (
            .clk (clk), .reset (reset), .phase_i (phase_i),
            .grow_a_i (unit_grow[e]), .grow_b_i (unit_grow[e+GRID_COLS]),
            .grown_o (ns_grown[e])
        );
    end

    for (genvar e = 0; e < EW_EDGE_COUNT; e++) begin : g_ew
        localparam int WU = (e / (GRID_COLS - 1)) * GRID_COLS + (e % (GRID_COLS - 1));
        edge_link #(.MAX_WEIGHT(MAX_WEIGHT), .IS_BOUNDARY(1'b0)) u_link (
            .clk (clk), .reset (reset), .phase_i (phase_i),
            .grow_a_i (unit_grow[WU]), .grow_b_i (unit_grow[WU+1]),
            .grown_o (ew_grown[e])
        );
    end

    for (genvar b = 0; b < BND_EDGE_COUNT; b++) begin : g_bnd
        localparam int ROW = b % GRID_ROWS;
        localparam int BU  = ROW * GRID_COLS + ((b < GRID_ROWS) ? 0 : GRID_COLS - 1);
        edge_link #(.MAX_WEIGHT(MAX_WEIGHT), .IS_BOUNDARY(1'b1)) u_link (
            .clk (clk), .reset (reset), .phase_i (phase_i),
            .grow_a_i (unit_grow[BU]), .grow_b_i (1'b0),
            .grown_o (bnd_grown[b])
        );
    end

    always_comb begin
        for (int u = 0; u < UNIT_COUNT; u++) begin
            result_o.roots[u] = status_o[u].root;
        end
        result_o.grown = {bnd_grown, ew_grown, ns_grown};  // NS edges at the low end
    end

    assign any_busy_o = |unit_busy;

endmodule

// ==== design/phase_controller.sv ====
`timescale 1ns/100ps

module phase_controller (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               meas_valid_i,
    output logic                               meas_ready_o,
    input  logic [decoder_pkg::UNIT_COUNT-1:0] meas_i,
    output logic [decoder_pkg::UNIT_COUNT-1:0] frame_o,
    output decoder_pkg::phase_e                phase_o,
    input  logic                               any_busy_i,
    input  logic                               any_odd_i,
    output logic                               result_valid_o,
    input  logic                               result_ready_i
);
    import decoder_pkg::*;

    phase_e                phase_q;
    logic [UNIT_COUNT-1:0] frame_q;

    assign meas_ready_o   = (phase_q == IDLE);  // One frame in flight
    assign result_valid_o = (phase_q == DONE);
    assign phase_o        = phase_q;
    assign frame_o        = frame_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase_q <= IDLE;
        end else begin
            case (phase_q)
                IDLE: begin
                    if (meas_valid_i) begin
                        phase_q <= LOAD;
                    end
                end
                LOAD: begin
                    phase_q <= CHECK;
                end
                CHECK: begin
                    if (any_odd_i) begin
                        phase_q <= GROW;
                    end else begin
                        phase_q <= DONE;  // Every cluster even or on a boundary
                    end
                end
                GROW: begin
                    phase_q <= MERGE;
                end
                MERGE: begin
                    if (!any_busy_i) begin
                        phase_q <= CHECK;  // Roots settled
                    end
                end
                DONE: begin
                    if (result_ready_i) begin
                        phase_q <= IDLE;
                    end
                end
                default: begin
                    phase_q <= IDLE;
                end
            endcase
        end
    end

    // Frame stays put until the next accept, parity reads it all decode long
    always_ff @(posedge clk) begin
        if (meas_valid_i && meas_ready_o) begin
            frame_q <= meas_i;
        end
    end

    a_result_held: assert property (
        @(posedge clk) disable iff (reset)
        (result_valid_o && !result_ready_i) |=> result_valid_o
    );

endmodule

// ==== design/decoding_graph_top.sv ====
`timescale 1ns/100ps

module decoding_graph_top #(
    parameter int MAX_WEIGHT = 2
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               meas_valid_i,
    output logic                               meas_ready_o,
    input  logic [decoder_pkg::UNIT_COUNT-1:0] meas_i,
    output logic                               result_valid_o,
    input  logic                               result_ready_i,
    output decoder_pkg::decode_result_t        result_o
);
    import decoder_pkg::*;

    phase_e                           phase;
    logic [UNIT_COUNT-1:0]            frame;   // Held for the whole decode
    logic [UNIT_COUNT-1:0]            odd;
    unit_status_t [UNIT_COUNT-1:0]    status;
    logic                             any_busy;
    logic                             any_odd;

    phase_controller u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .meas_valid_i   (meas_valid_i),
        .meas_ready_o   (meas_ready_o),
        .meas_i         (meas_i),
        .frame_o        (frame),
        .phase_o        (phase),
        .any_busy_i     (any_busy),
        .any_odd_i      (any_odd),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i)
    );

    decoding_lattice #(.MAX_WEIGHT(MAX_WEIGHT)) u_lattice (
        .clk        (clk),
        .reset      (reset),
        .phase_i    (phase),
        .frame_i    (frame),
        .odd_i      (odd),
        .status_o   (status),
        .any_busy_o (any_busy),
        .result_o   (result_o)
    );

    cluster_parity u_parity (
        .status_i  (status),
        .defect_i  (frame),
        .odd_o     (odd),
        .any_odd_o (any_odd)
    );

endmodule

// ==== dv/decoder_model.svh ====
`ifndef DECODER_MODEL_SVH
`define DECODER_MODEL_SVH

// Endpoint of edge e in result order, -1 for the far end of a boundary edge
function automatic int edge_endpoint(input int e, input bit far_end);
    int b;
    if (e < NS_EDGE_COUNT) begin
        return far_end ? e + GRID_COLS : e;  // Upper unit, then the one below
    end
    if (e < NS_EDGE_COUNT + EW_EDGE_COUNT) begin
        b = e - NS_EDGE_COUNT;
        return (b / (GRID_COLS - 1)) * GRID_COLS + b % (GRID_COLS - 1) + (far_end ? 1 : 0);
    end
    if (far_end) begin
        return -1;
    end
    b = e - NS_EDGE_COUNT - EW_EDGE_COUNT;
    return (b % GRID_ROWS) * GRID_COLS + ((b < GRID_ROWS) ? 0 : GRID_COLS - 1);
endfunction

// Growth rounds until every cluster is even or touches a grown boundary edge
function automatic decode_result_t decode_reference(input logic [UNIT_COUNT-1:0] defects,
                                                    input int max_weight);
    int             count [EDGE_COUNT];
    int             root [UNIT_COUNT];
    bit             par [UNIT_COUNT];    // Indexed by root
    bit             touch [UNIT_COUNT];  // Indexed by root
    bit             odd [UNIT_COUNT];
    bit             any_odd;
    bit             changed;
    int             a;
    int             b;
    int             m;
    int             inc;
    decode_result_t res;

    foreach (count[e]) count[e] = 0;
    any_odd = 1'b1;
    while (any_odd) begin
        foreach (root[u]) root[u] = u;
        changed = 1'b1;
        while (changed) begin  // Smallest address spreads over full internal edges
            changed = 1'b0;
            for (int e = 0; e < NS_EDGE_COUNT + EW_EDGE_COUNT; e++) begin
                a = edge_endpoint(e, 1'b0);
                b = edge_endpoint(e, 1'b1);
                m = (root[a] < root[b]) ? root[a] : root[b];
                if (count[e] == max_weight && (root[a] != m || root[b] != m)) begin
                    root[a] = m;
                    root[b] = m;
                    changed = 1'b1;
                end
            end
        end
        foreach (par[u]) begin
            par[u]   = 1'b0;
            touch[u] = 1'b0;
        end
        for (int e = NS_EDGE_COUNT + EW_EDGE_COUNT; e < EDGE_COUNT; e++) begin
            if (count[e] == max_weight) begin
                touch[root[edge_endpoint(e, 1'b0)]] = 1'b1;
            end
        end
        foreach (root[u]) par[root[u]] ^= defects[u];
        any_odd = 1'b0;
        foreach (odd[u]) begin
            odd[u]  = par[root[u]] && !touch[root[u]];
            any_odd = any_odd | odd[u];
        end
        if (any_odd) begin
            for (int e = 0; e < EDGE_COUNT; e++) begin
                a   = edge_endpoint(e, 1'b0);
                b   = edge_endpoint(e, 1'b1);
                inc = odd[a];  // One step per odd endpoint
                if (b >= 0) begin
                    inc += odd[b];
                end
                count[e] = (count[e] + inc > max_weight) ? max_weight : count[e] + inc;
            end
        end
    end
    foreach (root[u]) res.roots[u] = unit_addr_t'(root[u]);
    for (int e = 0; e < EDGE_COUNT; e++) begin
        res.grown[e] = (count[e] == max_weight);
    end
    return res;
endfunction

`endif

// ==== dv/tb_decoding_graph.sv ====
`timescale 1ns/100ps

module tb_decoding_graph;
    import decoder_pkg::*;

    localparam int MAX_WEIGHT  = 2;
    localparam int RES_W       = $bits(decode_result_t);
    localparam int FRAME_COUNT = 204;  // Three directed, 200 random, one back-pressure
    localparam int FRAME_BOUND = GRID_ROWS * GRID_COLS * MAX_WEIGHT * 8;
    localparam int HOLD_MAX    = 16;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  meas_valid_i;
    logic                  meas_ready_o;
    logic [UNIT_COUNT-1:0] meas_i;
    logic                  result_valid_o;
    logic                  result_ready_i;
    decode_result_t        result_o;

    decode_result_t expected_q[$];
    decode_result_t last_result;
    int unsigned    lcg_state = 15100;
    int             results_seen = 0;
    string          test_name = "reset";

    `include "decoder_model.svh"

    decoding_graph_top #(.MAX_WEIGHT(MAX_WEIGHT)) dut (
        .clk            (clk),
        .reset          (reset),
        .meas_valid_i   (meas_valid_i),
        .meas_ready_o   (meas_ready_o),
        .meas_i         (meas_i),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .result_o       (result_o)
    );

    always #5 clk = ~clk;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;  // Upper bits are the better mixed ones
    endfunction

    task automatic check_value(input string name, input logic [RES_W-1:0] expected,
                               input logic [RES_W-1:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Check failed in %s", name);
        end
    endtask

    // Every result transfer is compared with the oldest outstanding frame
    always @(posedge clk) begin
        if (!reset && result_valid_o && result_ready_i) begin
            if (expected_q.size() == 0) begin
                $display("A result was transferred while no frame was outstanding");
                $display("SOME TESTS FAILED");
                $fatal(1, "Unexpected result");
            end else begin
                check_value(test_name, expected_q.pop_front(), result_o);
                last_result  = result_o;
                results_seen = results_seen + 1;
            end
        end
    end

    task automatic send_frame(input logic [UNIT_COUNT-1:0] frame);
        @(negedge clk);
        meas_valid_i = 1'b1;
        meas_i       = frame;
        @(posedge clk);
        while (!meas_ready_o) @(posedge clk);
        expected_q.push_back(decode_reference(frame, MAX_WEIGHT));
        @(negedge clk);
        meas_valid_i = 1'b0;
    endtask

    task automatic decode_frame(input logic [UNIT_COUNT-1:0] frame);
        int target;
        target = results_seen + 1;
        send_frame(frame);
        wait (results_seen == target);
    endtask

    task automatic backpressure_frame(input logic [UNIT_COUNT-1:0] frame, input int hold);
        decode_result_t held;
        int             target;
        target = results_seen + 1;
        @(negedge clk);
        result_ready_i = 1'b0;
        send_frame(frame);
        @(posedge clk);
        while (!result_valid_o) @(posedge clk);
        held = result_o;
        repeat (hold) begin
            @(posedge clk);
            check_value("backpressure valid held", 1'b1, result_valid_o);
            check_value("backpressure result stable", held, result_o);
            check_value("backpressure meas_ready low", 1'b0, meas_ready_o);
        end
        @(negedge clk);
        result_ready_i = 1'b1;
        wait (results_seen == target);
        @(posedge clk);
        check_value("backpressure meas_ready restored", 1'b1, meas_ready_o);
    endtask

    initial begin
        logic [UNIT_COUNT-1:0] frame;
        decode_result_t        plain;
        reset          = 1'b1;
        meas_valid_i   = 1'b0;
        meas_i         = '0;
        result_ready_i = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_name = "all_zero";
        decode_frame('0);
        foreach (plain.roots[u]) plain.roots[u] = unit_addr_t'(u);  // Every unit its own root
        plain.grown = '0;
        check_value(test_name, plain, last_result);

        test_name = "single_defect";
        frame = '0;
        frame[GRID_COLS + GRID_COLS / 2] = 1'b1;  // Row 1, middle column
        decode_frame(frame);
        check_value("single_defect boundary", 1'b1,
                    |last_result.grown[EDGE_COUNT-1 -: BND_EDGE_COUNT]);

        test_name = "adjacent_pair";
        frame = '0;
        frame[GRID_COLS + 1] = 1'b1;
        frame[GRID_COLS + 2] = 1'b1;
        decode_frame(frame);
        check_value("adjacent_pair root low", GRID_COLS + 1, last_result.roots[GRID_COLS + 1]);
        check_value("adjacent_pair root high", GRID_COLS + 1, last_result.roots[GRID_COLS + 2]);
        check_value("adjacent_pair boundary", '0,
                    last_result.grown[EDGE_COUNT-1 -: BND_EDGE_COUNT]);

        test_name = "random_frames";
        repeat (200) begin
            for (int u = 0; u < UNIT_COUNT; u++) begin
                frame[u] = (lcg_next() % 5 == 0);  // About a fifth of the bits set
            end
            decode_frame(frame);
        end

        test_name = "backpressure";
        for (int u = 0; u < UNIT_COUNT; u++) begin
            frame[u] = (lcg_next() % 5 == 0);
        end
        backpressure_frame(frame, 1 + lcg_next() % HOLD_MAX);

        if (expected_q.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "Run ended with %0d frames still outstanding", expected_q.size());
        end
    end

    initial begin
        #((FRAME_COUNT * FRAME_BOUND + 16 + 2 * HOLD_MAX) * 10);
        $display("Timeout: the decoder did not finish all frames in time");
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== filelist.f ====
+incdir+dv
design/decoder_pkg.sv
design/edge_link.sv
design/processing_unit.sv
design/cluster_parity.sv
design/decoding_lattice.sv
design/phase_controller.sv
design/decoding_graph_top.sv
dv/tb_decoding_graph.sv
